//--- Bender.yml
package:
  name: packetizer

export_include_dirs:
  - .

sources:
  # design, in compile order
  - files:
      - packetizer_pkg.sv
      - word_sram.sv
      - filter_fetch.sv
      - ifmap_fetch.sv
      - packet_merge.sv
      - packetizer_top.sv
  # testbench
  - target: test
    files:
      - tb_packetizer.sv

//--- filter_fetch.sv
`timescale 1ns/1ns

`include "packetizer_cfg.svh"

module filter_fetch
    import packetizer_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    // request stream shared with the ifmap path
    input  logic           req_valid,
    input  request_t       req,
    // filter store loader
    input  logic           wr_valid,
    input  fil_addr_t      wr_addr,
    input  filter_word_t   wr_data,
    // result towards the merge unit
    output logic           res_valid,
    output filter_result_t res
);

    logic         fil_req;   // filter request this cycle
    fil_addr_t    rd_row;    // row picked out of loc_y
    filter_word_t rd_word;   // memory output one cycle after the read
    node_t        node_q;
    fil_addr_t    row_q;

    assign fil_req = req_valid & req.is_filter;
    assign rd_row  = req.loc_y[`PKT_ROW_W-1:0];

    // one word per filter row
    word_sram #(
        .word_t (filter_word_t),
        .DEPTH  (`PKT_FIL_DEPTH)
    ) fil_mem_i (
        .clk     (clk),
        .wr_en   (wr_valid),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_row),   // read every cycle and let the strobe decide
        .rd_data (rd_word)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= fil_req; // one-cycle strobe lined up with rd_word
        end
    end

    // routing fields ride alongside the memory read
    always_ff @(posedge clk) begin
        if (fil_req) begin
            node_q <= req.pe_node;
            row_q  <= rd_row;
        end
    end

    always_comb begin
        res.pe_node = node_q;
        res.row     = row_q;
        res.data    = rd_word;
    end

    // strobe one cycle on carries the word stored at the requested row
    res_follows_req: assert property (
        @(posedge clk) disable iff (reset)
        fil_req |=> res_valid && (res.data === $past(fil_mem_i.mem[rd_row]))
    ) else begin
        $error("filter_fetch result out of step with request");
    end

endmodule

//--- ifmap_fetch.sv
`timescale 1ns/1ns

module ifmap_fetch
    import packetizer_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    // request stream shared with the filter path
    input  logic          req_valid,
    input  request_t      req,
    // sticky filter size config
    input  logic          fil_size_valid,
    input  fil_size_t     fil_size,
    // ifmap store loader
    input  logic          wr_valid,
    input  if_addr_t      wr_addr,
    input  ifmap_word_t   wr_data,
    // result towards the merge unit
    output logic          res_valid,
    output ifmap_result_t res
);

    logic        if_req;     // ifmap request this cycle
    if_addr_t    rd_addr;
    ifmap_word_t rd_word;
    fil_size_t   fil_size_q; // current filter size
    node_t       node_q;
    logic        ts_q;
    loc_t        x_q;
    loc_t        y_q;
    fil_size_t   res_fsize_q; // size as seen by this request

    assign if_req  = req_valid & ~req.is_filter;
    assign rd_addr = {req.timestep, req.loc_y, req.loc_x}; // timestep, y, x

    word_sram #(
        .word_t (ifmap_word_t),
        .DEPTH  (IF_DEPTH)
    ) if_mem_i (
        .clk     (clk),
        .wr_en   (wr_valid),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_word)
    );

    // a new size only reaches requests after its own edge
    always_ff @(posedge clk) begin
        if (reset) begin
            fil_size_q <= '0;
        end else if (fil_size_valid) begin
            fil_size_q <= fil_size;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= if_req;
        end
    end

    // payload captured with the read
    always_ff @(posedge clk) begin
        if (if_req) begin
            node_q      <= req.pe_node;
            ts_q        <= req.timestep;
            x_q         <= req.loc_x;
            y_q         <= req.loc_y;
            res_fsize_q <= fil_size_q;   // old size on a same-edge update
        end
    end

    always_comb begin
        res.pe_node  = node_q;
        res.timestep = ts_q;
        res.loc_x    = x_q;
        res.loc_y    = y_q;
        res.fil_size = res_fsize_q;
        res.data     = rd_word;
    end

endmodule

//--- packet_merge.sv
`timescale 1ns/1ns

module packet_merge
    import packetizer_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    // filter path result
    input  logic           fil_res_valid,
    input  filter_result_t fil_res,
    // ifmap path result
    input  logic           if_res_valid,
    input  ifmap_result_t  if_res,
    // noc side, no back-pressure
    output logic           pkt_valid,
    output noc_packet_t    pkt
);

    logic        any_valid;
    node_t       node_sel;   // destination of whichever path finished
    noc_packet_t pkt_d;      // next packet

    assign any_valid = fil_res_valid | if_res_valid;
    assign node_sel  = fil_res_valid ? fil_res.pe_node : if_res.pe_node;

    // build the flit for the kind that is valid, unused fields stay zero
    always_comb begin
        pkt_d        = '0;
        pkt_d.header = route_header(node_sel);
        if (fil_res_valid) begin
            pkt_d.data      = fil_res.data.coef;
            pkt_d.row       = fil_res.row;
            pkt_d.is_filter = 1'b1;
        end else begin
            pkt_d.data      = if_res.data.pixel;
            pkt_d.loc_x     = if_res.loc_x;
            pkt_d.loc_y     = if_res.loc_y;
            pkt_d.fil_size  = if_res.fil_size;
            pkt_d.timestep  = if_res.timestep;
            pkt_d.is_filter = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pkt_valid <= 1'b0;
        end else begin
            pkt_valid <= any_valid; // one flit per result
        end
    end

    // flit register, holds its last value between strobes
    always_ff @(posedge clk) begin
        if (any_valid) begin
            pkt <= pkt_d;
        end
    end

    // both fetch paths have the same latency and requests come one per cycle,
    // so a clash here means the upstream contract broke
    results_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(fil_res_valid && if_res_valid)
    ) else begin
        $error("packet_merge saw filter and ifmap results together");
    end

endmodule

//--- packetizer.f
+incdir+.
packetizer_pkg.sv
word_sram.sv
filter_fetch.sv
ifmap_fetch.sv
packet_merge.sv
packetizer_top.sv
tb_packetizer.sv

//--- packetizer_cfg.svh
`ifndef PACKETIZER_CFG_SVH
`define PACKETIZER_CFG_SVH

// fetched word, filter and ifmap alike
`define PKT_DATA_W          25

// one ifmap coordinate, x or y
`define PKT_LOC_W           6

// pe node number and count of real nodes
`define PKT_NODE_W          4
`define PKT_NUM_PE          14

// filter store holds one word per filter row
`define PKT_FIL_DEPTH       8
`define PKT_ROW_W           3

// ifmap address is {timestep, y, x}
`define PKT_IF_ADDR_W       13

`define PKT_FSIZE_W         2
`define PKT_HDR_W           8

// route code of node 0, also used for nodes past the last pe
`define PKT_DEFAULT_ROUTE   8'b1110_0011

`endif

//--- packetizer_pkg.sv
`include "packetizer_cfg.svh"

package packetizer_pkg;

    localparam int IF_DEPTH = 1 << `PKT_IF_ADDR_W; // words in the ifmap store

    typedef logic [`PKT_NODE_W-1:0]    node_t;
    typedef logic [`PKT_LOC_W-1:0]     loc_t;
    typedef logic [`PKT_ROW_W-1:0]     fil_addr_t;   // filter row doubles as address
    typedef logic [`PKT_IF_ADDR_W-1:0] if_addr_t;
    typedef logic [`PKT_FSIZE_W-1:0]   fil_size_t;
    typedef logic [`PKT_HDR_W-1:0]     header_t;

    // wrapped so a filter word cannot land in the ifmap store by accident
    typedef struct packed {
        logic [`PKT_DATA_W-1:0] coef;
    } filter_word_t;

    typedef struct packed {
        logic [`PKT_DATA_W-1:0] pixel;
    } ifmap_word_t;

    // one word popped from the request fifo, 18 bits
    typedef struct packed {
        node_t pe_node;
        loc_t  loc_x;
        loc_t  loc_y;     // low bits give the row on filter requests
        logic  timestep;
        logic  is_filter;
    } request_t;

    typedef struct packed {
        node_t        pe_node;
        fil_addr_t    row;
        filter_word_t data;
    } filter_result_t;

    typedef struct packed {
        node_t       pe_node;
        logic        timestep;
        loc_t        loc_x;
        loc_t        loc_y;
        fil_size_t   fil_size;
        ifmap_word_t data;
    } ifmap_result_t;

    // outgoing noc flit, 53 bits, header at the bottom
    typedef struct packed {
        logic [`PKT_DATA_W-1:0] data;
        logic                   spare;     // tied low
        loc_t                   loc_x;
        loc_t                   loc_y;
        fil_size_t              fil_size;
        fil_addr_t              row;
        logic                   is_filter;
        logic                   timestep;
        header_t                header;
    } noc_packet_t;

    // xy route code per destination pe
    function automatic header_t route_header(input node_t node);
        case (node)
            4'd0:    return `PKT_DEFAULT_ROUTE;
            4'd1:    return 8'b1111_0011;
            4'd2:    return 8'b1111_1011;
            4'd3:    return 8'b1100_0011;
            4'd4:    return 8'b1101_0011;
            4'd5:    return 8'b1101_1011;
            4'd6:    return 8'b1101_1111;
            4'd7:    return 8'b1000_0011;
            4'd8:    return 8'b1001_0011;
            4'd9:    return 8'b1001_1011;
            4'd10:   return 8'b1001_1111;
            4'd11:   return 8'b0001_0011;
            4'd12:   return 8'b0001_1011;
            4'd13:   return 8'b0001_1111;
            default: return `PKT_DEFAULT_ROUTE; // nodes 14, 15 fall back to node 0
        endcase
    endfunction

endpackage

//--- packetizer_top.sv
`timescale 1ns/1ns

module packetizer_top
    import packetizer_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    // request fifo side
    input  logic         req_valid,
    input  request_t     req,
    // filter size config
    input  logic         fil_size_valid,
    input  fil_size_t    fil_size,
    // memory loaders
    input  logic         fil_wr_valid,
    input  fil_addr_t    fil_wr_addr,
    input  filter_word_t fil_wr_data,
    input  logic         if_wr_valid,
    input  if_addr_t     if_wr_addr,
    input  ifmap_word_t  if_wr_data,
    // noc side, two cycles after the request
    output logic         pkt_valid,
    output noc_packet_t  pkt
);

    logic           fil_res_valid;
    filter_result_t fil_res;
    logic           if_res_valid;
    ifmap_result_t  if_res;

    // both paths see every request and pick their own kind
    filter_fetch filter_fetch_i (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .wr_valid  (fil_wr_valid),
        .wr_addr   (fil_wr_addr),
        .wr_data   (fil_wr_data),
        .res_valid (fil_res_valid),
        .res       (fil_res)
    );

    ifmap_fetch ifmap_fetch_i (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req            (req),
        .fil_size_valid (fil_size_valid),
        .fil_size       (fil_size),
        .wr_valid       (if_wr_valid),
        .wr_addr        (if_wr_addr),
        .wr_data        (if_wr_data),
        .res_valid      (if_res_valid),
        .res            (if_res)
    );

    packet_merge packet_merge_i (
        .clk           (clk),
        .reset         (reset),
        .fil_res_valid (fil_res_valid),
        .fil_res       (fil_res),
        .if_res_valid  (if_res_valid),
        .if_res        (if_res),
        .pkt_valid     (pkt_valid),
        .pkt           (pkt)
    );

endmodule

//--- tb_packetizer.sv
`timescale 1ns/1ns

`include "packetizer_cfg.svh"

module tb_packetizer
    import packetizer_pkg::*;
;

    logic         clk = 1'b0;
    logic         reset;
    logic         req_valid;
    request_t     req;
    logic         fil_size_valid;
    fil_size_t    fil_size;
    logic         fil_wr_valid;
    fil_addr_t    fil_wr_addr;
    filter_word_t fil_wr_data;
    logic         if_wr_valid;
    if_addr_t     if_wr_addr;
    ifmap_word_t  if_wr_data;
    logic         pkt_valid;
    noc_packet_t  pkt;

    filter_word_t fil_shadow [`PKT_FIL_DEPTH]; // what the filter store should hold
    ifmap_word_t  if_shadow [IF_DEPTH];
    fil_size_t    fsize_shadow;
    noc_packet_t  exp_q [$];                   // expected packets, oldest first
    int           due_q [$];                   // cycle each one is due
    int           cycle = 0;
    logic         run_checks = 1'b0;
    int           checks = 0;
    int           errors = 0;
    int           err_mark = 0;
    int           packets = 0;

    packetizer_top packetizer_top_i (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle      <= cycle + 1;
        run_checks <= !reset; // stable by the next falling edge
    end

    task automatic compare_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_packet(string name, noc_packet_t got, noc_packet_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // expected flit straight from the packet layout and the xy route table
    function automatic noc_packet_t expected_packet(request_t r, fil_size_t fsize);
        noc_packet_t p;
        fil_addr_t   row;
        p   = '0;
        row = r.loc_y[`PKT_ROW_W-1:0];
        if (r.is_filter) begin
            p.data      = fil_shadow[row].coef;
            p.row       = row;
            p.is_filter = 1'b1;
        end else begin
            p.data     = if_shadow[{r.timestep, r.loc_y, r.loc_x}].pixel;
            p.loc_x    = r.loc_x;
            p.loc_y    = r.loc_y;
            p.fil_size = fsize;
            p.timestep = r.timestep;
        end
        case (r.pe_node)
            4'd1:    p.header = 8'b1111_0011;
            4'd2:    p.header = 8'b1111_1011;
            4'd3:    p.header = 8'b1100_0011;
            4'd4:    p.header = 8'b1101_0011;
            4'd5:    p.header = 8'b1101_1011;
            4'd6:    p.header = 8'b1101_1111;
            4'd7:    p.header = 8'b1000_0011;
            4'd8:    p.header = 8'b1001_0011;
            4'd9:    p.header = 8'b1001_1011;
            4'd10:   p.header = 8'b1001_1111;
            4'd11:   p.header = 8'b0001_0011;
            4'd12:   p.header = 8'b0001_1011;
            4'd13:   p.header = 8'b0001_1111;
            default: p.header = 8'b1110_0011; // node 0, also 14 and 15
        endcase
        return p;
    endfunction

    function automatic logic [`PKT_DATA_W-1:0] random_word();
        logic [31:0] rnd;
        rnd = $urandom();
        return rnd[`PKT_DATA_W-1:0];
    endfunction

    // unused fields get random junk
    function automatic request_t make_req(node_t node, logic is_filter);
        request_t    r;
        logic [31:0] rnd;
        rnd         = $urandom();
        r           = request_t'(rnd[$bits(request_t)-1:0]);
        r.pe_node   = node;
        r.is_filter = is_filter;
        return r;
    endfunction

    function automatic node_t random_node();
        return node_t'($urandom_range(`PKT_NUM_PE-1, 0));
    endfunction

    task automatic issue(request_t r);
        req_valid = 1'b1;
        req       = r;
        exp_q.push_back(expected_packet(r, fsize_shadow));
        due_q.push_back(cycle + 2); // sampled next edge, packet one edge later
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic write_filter(fil_addr_t addr, filter_word_t w);
        fil_wr_valid     = 1'b1;
        fil_wr_addr      = addr;
        fil_wr_data      = w;
        fil_shadow[addr] = w;
        @(negedge clk);
        fil_wr_valid = 1'b0;
    endtask

    task automatic write_ifmap(if_addr_t addr, ifmap_word_t w);
        if_wr_valid     = 1'b1;
        if_wr_addr      = addr;
        if_wr_data      = w;
        if_shadow[addr] = w;
        @(negedge clk);
        if_wr_valid = 1'b0;
    endtask

    task automatic set_fil_size(fil_size_t s);
        fil_size_valid = 1'b1;
        fil_size       = s;
        fsize_shadow   = s;
        @(negedge clk);
        fil_size_valid = 1'b0;
    endtask

    task automatic finish_test(int num, string name);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 50) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout in test %0d: %0d packets never came out", num, exp_q.size());
            $display("Testbench failed");
            $finish;
        end
        @(negedge clk);
        $display("test %0d %s done, %0d errors", num, name, errors - err_mark);
        err_mark = errors;
    endtask

    // strobe must match the due list every cycle, payload checked when due
    always @(negedge clk) begin : compare_proc
        logic        due;
        noc_packet_t exp_pkt;
        if (run_checks) begin
            due = (due_q.size() > 0) && (due_q[0] == cycle);
            compare_bit("pkt_valid", pkt_valid, due);
            if (due) begin
                exp_pkt = exp_q.pop_front();
                void'(due_q.pop_front());
                if (pkt_valid) begin
                    compare_packet("pkt", pkt, exp_pkt);
                    packets++;
                end
            end
        end
    end

    initial begin
        request_t    r;
        filter_word_t fw;
        ifmap_word_t iw;
        if_addr_t    a;
        void'($urandom(62));
        reset          = 1'b1;
        req_valid      = 1'b0;
        req            = '0;
        fil_size_valid = 1'b0;
        fil_size       = '0;
        fil_wr_valid   = 1'b0;
        fil_wr_addr    = '0;
        fil_wr_data    = '0;
        if_wr_valid    = 1'b0;
        if_wr_addr     = '0;
        if_wr_data     = '0;
        fsize_shadow   = '0;   // reset value of the size register
        repeat (4) @(negedge clk);
        reset = 1'b0;

        repeat (10) @(negedge clk); // quiet, checker expects pkt_valid low
        finish_test(1, "idle after reset");

        for (int i = 0; i < `PKT_FIL_DEPTH; i++) begin
            fw.coef = random_word();
            write_filter(fil_addr_t'(i), fw);
        end
        for (int i = 0; i < IF_DEPTH; i++) begin
            iw.pixel = random_word();
            write_ifmap(if_addr_t'(i), iw);
        end

        for (int row = 0; row < `PKT_FIL_DEPTH; row++) begin
            for (int node = 0; node < `PKT_NUM_PE; node++) begin
                r = make_req(node_t'(node), 1'b1);
                r.loc_y[`PKT_ROW_W-1:0] = fil_addr_t'(row);
                issue(r);
                if ($urandom_range(1, 0) == 1) @(negedge clk); // random gap
            end
        end
        finish_test(2, "filter rows");

        for (int s = 0; s < 4; s++) begin
            if (s != 0) set_fil_size(fil_size_t'(s));
            repeat (30) issue(make_req(random_node(), 1'b0));
        end
        finish_test(3, "ifmap and filter size");

        repeat (200) issue(make_req(random_node(), $urandom_range(1, 0) == 1));
        finish_test(4, "back to back mix");

        for (int n = 14; n < 16; n++) begin
            issue(make_req(node_t'(n), 1'b0));
            issue(make_req(node_t'(n), 1'b1));
        end
        finish_test(5, "nodes past last pe");

        r = make_req(random_node(), 1'b1);
        issue(r);
        fw.coef = random_word();
        write_filter(r.loc_y[`PKT_ROW_W-1:0], fw);
        issue(r);                                   // must see the new word
        r = make_req(random_node(), 1'b0);
        a = {r.timestep, r.loc_y, r.loc_x};
        issue(r);
        iw.pixel = random_word();
        write_ifmap(a, iw);
        issue(r);
        finish_test(6, "memory rewrite");

        $display("checks %0d, packets %0d, errors %0d", checks, packets, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- word_sram.sv
`timescale 1ns/1ns

module word_sram #(
    parameter type word_t = logic,
    parameter int  DEPTH  = 8,
    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  word_t             wr_data,
    input  logic [ADDR_W-1:0] rd_addr,
    output word_t             rd_data
);

    word_t mem [DEPTH]; // storage only, contents come from the loader

    // one write port, one registered read port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr]; // same-edge write is not seen here, old word wins
    end

    // a non power of two depth leaves holes in the address space
    wr_addr_in_range: assert property (
        @(posedge clk) wr_en |-> (wr_addr < DEPTH)
    ) else begin
        $error("word_sram write to %0d, depth %0d", wr_addr, DEPTH);
    end

    // read side has no enable, so only check once the address is driven
    rd_addr_in_range: assert property (
        @(posedge clk) !$isunknown(rd_addr) |-> (rd_addr < DEPTH)
    ) else begin
        $error("word_sram read from %0d, depth %0d", rd_addr, DEPTH);
    end

endmodule
